//--- cache_back_end.f
+incdir+rtl
rtl/cache_be_pkg.sv
rtl/write_through_buffer.sv
rtl/write_through_ctrl.sv
rtl/line_refill_ctrl.sv
rtl/mem_port_arbiter.sv
rtl/cache_back_end.sv
verification/cache_back_end_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --timing
TOP       = cache_back_end_tb
FILELIST  = cache_back_end.f
OBJ_DIR   = obj_dir
PASS_MSG  = RESULT: PASS

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- verification/cache_back_end_tb.sv
`timescale 1ns/100ps
`include "cache_be_defs.svh"

module cache_back_end_tb;

   import cache_be_pkg::*;

   localparam line_addr_t LINE_BASE = 27'h0123450;   // four neighbouring lines

   logic clk = 1'b0;
   logic reset;
   logic write_valid, write_ready, replace_valid, replace_ready, read_valid;
   fe_waddr_t write_addr;
   fe_word_t write_wdata;
   fe_strb_t write_wstrb;
   line_addr_t replace_addr;
   beat_idx_t read_addr;
   be_word_t read_rdata, mem_wdata, mem_rdata;
   logic mem_valid, mem_ready;
   be_addr_t mem_addr;
   be_strb_t mem_wstrb;

   be_word_t mem_model [be_addr_t];   // memory behind the port
   fe_word_t ref_mem [fe_waddr_t];    // what the cache has written
   wtb_entry_t exp_q [$];             // accepted writes not yet in memory
   logic [31:0] rng_stim = 32'h3449;
   logic [31:0] rng_mem = 32'h3449;
   int wait_left = -1;
   int accepted_cnt = 0, written_cnt = 0, started_cnt = 0, refills_done = 0;
   logic hold_mem = 1'b0, hold_q = 1'b0;
   logic req_held = 1'b0, rf_active = 1'b0, end_chk = 1'b0;
   be_addr_t held_addr;
   be_word_t held_wdata;
   be_strb_t held_wstrb;
   line_addr_t rf_line;
   beat_idx_t rf_beat;
   logic [3:0] touched = 4'h0;

   cache_back_end dut0 (.*);

   always #10 clk = ~clk;

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic line_addr_t line_of(input int idx);
      return LINE_BASE + line_addr_t'(idx);
   endfunction

   function automatic be_word_t read_mem(input be_addr_t a);
      return mem_model.exists(a) ? mem_model[a] : '0;
   endfunction

   function automatic fe_word_t ref_word(input line_addr_t l, input beat_idx_t b, input logic h);
      fe_waddr_t key;
      key = {l, b, h};
      return ref_mem.exists(key) ? ref_mem[key] : '0;
   endfunction

   function automatic be_word_t strb_mask(input be_strb_t s);
      be_word_t m;
      for (int i = 0; i < 8; i++)
         m[8*i +: 8] = {8{s[i]}};
      return m;
   endfunction

   task automatic report_failure(input string why);
      $display("%s", why);
      $display("RESULT: FAIL");
      $fatal(1, "stopped at first error");
   endtask

   task automatic compare_be_word(input string name, input be_word_t got, input be_word_t exp);
      if (got !== exp)
         report_failure($sformatf("Mismatch at %0t: %s is %h, expected %h", $time, name, got, exp));
   endtask

   task automatic compare_be_addr(input string name, input be_addr_t got, input be_addr_t exp);
      if (got !== exp)
         report_failure($sformatf("Mismatch at %0t: %s is %h, expected %h", $time, name, got, exp));
   endtask

   task automatic compare_be_strb(input string name, input be_strb_t got, input be_strb_t exp);
      if (got !== exp)
         report_failure($sformatf("Mismatch at %0t: %s is %h, expected %h", $time, name, got, exp));
   endtask

   task automatic compare_beat_idx(input string name, input beat_idx_t got, input beat_idx_t exp);
      if (got !== exp)
         report_failure($sformatf("Mismatch at %0t: %s is %0d, expected %0d",
                                  $time, name, got, exp));
   endtask

   task automatic compare_bit(input string name, input logic got, input logic exp);
      if (got !== exp)
         report_failure($sformatf("Mismatch at %0t: %s is %b, expected %b", $time, name, got, exp));
   endtask

   // port, refill and front-end checks of one cycle, sampled mid-cycle
   task automatic check_cycle();
      wtb_entry_t e;
      be_addr_t b;
      be_addr_t a;
      be_strb_t s;
      be_word_t m;
      fe_word_t w;
      if (end_chk)
         compare_bit("replace_ready", replace_ready, 1'b0);   // end cycle after last beat
      end_chk = 1'b0;
      if (req_held)
      begin
         if (!mem_valid)
            report_failure("mem_valid dropped before mem_ready");
         compare_be_addr("mem_addr", mem_addr, held_addr);
         compare_be_word("mem_wdata", mem_wdata, held_wdata);
         compare_be_strb("mem_wstrb", mem_wstrb, held_wstrb);
      end
      req_held = mem_valid && !mem_ready;
      held_addr = mem_addr;
      held_wdata = mem_wdata;
      held_wstrb = mem_wstrb;
      if (replace_ready && accepted_cnt != written_cnt)
         report_failure("replace_ready high while accepted writes are not in memory");
      if (mem_valid && mem_ready && mem_wstrb != '0)
      begin
         if (exp_q.size() == 0)
            report_failure("memory write with no accepted front-end write pending");
         e = exp_q.pop_front();
         b = {e.addr, 2'b00};                       // front-end byte address
         a = b & ~be_addr_t'(7);
         s = be_strb_t'(e.wstrb) << (4 * b[2]);   // addr bit 2 picks the half
         m = strb_mask(s);
         compare_be_addr("mem_addr", mem_addr, a);
         compare_be_strb("mem_wstrb", mem_wstrb, s);
         compare_be_word("mem_wdata", mem_wdata & m, {e.wdata, e.wdata} & m);
         mem_model[a] = (read_mem(a) & ~m) | (mem_wdata & m);
         written_cnt++;
      end
      if (mem_valid && mem_ready && mem_wstrb == '0 && !read_valid)
         report_failure("memory read without a refill beat");
      if (read_valid)
      begin
         if (!rf_active)
            report_failure("read_valid without an accepted replacement");
         compare_be_addr("mem_addr", mem_addr,
                         (be_addr_t'(rf_line) << 5) + (be_addr_t'(rf_beat) << 3));   // 32-byte lines
         compare_beat_idx("read_addr", read_addr, rf_beat);
         compare_be_word("read_rdata", read_rdata,
                         {ref_word(rf_line, rf_beat, 1'b1), ref_word(rf_line, rf_beat, 1'b0)});
         rf_beat = rf_beat + 2'd1;
         if (rf_beat == 2'd0)
         begin
            rf_active = 1'b0;
            end_chk = 1'b1;
            refills_done++;
         end
      end
      if (write_valid && write_ready)
      begin
         exp_q.push_back(wtb_entry_t'{addr: write_addr, wdata: write_wdata, wstrb: write_wstrb});
         w = ref_mem.exists(write_addr) ? ref_mem[write_addr] : '0;
         for (int i = 0; i < 4; i++)
            if (write_wstrb[i])
               w[8*i +: 8] = write_wdata[8*i +: 8];
         ref_mem[write_addr] = w;
         accepted_cnt++;
      end
      if (replace_valid && replace_ready)
      begin
         rf_line = replace_addr;
         rf_beat = '0;
         rf_active = 1'b1;
         started_cnt++;
      end
   endtask

   // memory answers after 0 to 3 cycles unless stalled
   always @(negedge clk)
   begin
      if (mem_valid && !hold_q)
      begin
         if (wait_left < 0)
         begin
            rng_mem = xorshift(rng_mem);
            wait_left = int'(rng_mem % 4);
         end
         mem_ready = (wait_left == 0);
         wait_left = wait_left - 1;
      end
      else
         mem_ready = 1'b0;
      mem_rdata = (mem_ready && mem_wstrb == '0) ? read_mem(mem_addr) : '0;
      #1;
      if (!reset)
         check_cycle();
      hold_q = hold_mem;
   end

   task automatic set_write_fields(input int idx);
      rng_stim = xorshift(rng_stim);
      write_addr = {line_of(idx), rng_stim[2:0]};
      write_wstrb = (rng_stim[7:4] == 4'h0) ? 4'hf : rng_stim[7:4];   // no strobes reads as a read
      rng_stim = xorshift(rng_stim);
      write_wdata = rng_stim;
      touched[idx] = 1'b1;
   endtask

   task automatic write_word(input int idx);
      int prev;
      int t;
      prev = accepted_cnt;
      set_write_fields(idx);
      write_valid = 1'b1;
      t = 0;
      do
      begin
         @(negedge clk);
         t++;
      end
      while (accepted_cnt == prev && t < 100);
      if (accepted_cnt == prev)
         report_failure("timeout waiting for a write to be accepted");
      write_valid = 1'b0;
   endtask

   task automatic refill_line(input int idx);
      int prev;
      int done;
      int t;
      prev = started_cnt;
      done = refills_done;
      replace_addr = line_of(idx);
      replace_valid = 1'b1;
      t = 0;
      do
      begin
         @(negedge clk);
         t++;
      end
      while (started_cnt == prev && t < 200);
      if (started_cnt == prev)
         report_failure("timeout waiting for replace_ready");
      replace_valid = 1'b0;
      t = 0;
      while (refills_done == done && t < 100)
      begin
         @(negedge clk);
         t++;
      end
      if (refills_done == done)
         report_failure("timeout waiting for the four refill beats");
   endtask

   initial
   begin
      int prev;
      int t;
      reset = 1'b1;
      write_valid = 1'b0;
      write_addr = '0;
      write_wdata = '0;
      write_wstrb = '0;
      replace_valid = 1'b0;
      replace_addr = '0;
      mem_ready = 1'b0;
      mem_rdata = '0;
      repeat (3) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      @(negedge clk);
      compare_bit("mem_valid", mem_valid, 1'b0);
      compare_bit("read_valid", read_valid, 1'b0);
      compare_bit("write_ready", write_ready, 1'b1);
      compare_bit("replace_ready", replace_ready, 1'b1);

      for (int n = 0; n < 80; n++)
      begin
         rng_stim = xorshift(rng_stim);
         if (rng_stim[2:0] == 3'd0)
            refill_line(int'(rng_stim[9:8]));
         else
            write_word(int'(rng_stim[9:8]));
      end

      // stall memory and push writes back to back until the buffer fills
      hold_mem = 1'b1;
      prev = accepted_cnt;
      set_write_fields(int'(rng_stim[11:10]));
      write_valid = 1'b1;
      t = 0;
      while (write_ready && t < 4 * `CACHE_WTB_DEPTH)
      begin
         @(negedge clk);
         t++;
         if (accepted_cnt != prev)
         begin
            prev = accepted_cnt;
            set_write_fields(int'(rng_stim[13:12]));
         end
      end
      if (write_ready)
         report_failure("write_ready stayed high while memory was stalled");
      repeat (6) @(negedge clk);
      hold_mem = 1'b0;
      t = 0;
      while (accepted_cnt == prev && t < 100)
      begin
         @(negedge clk);
         t++;
      end
      if (accepted_cnt == prev)
         report_failure("stalled write was never accepted");
      write_valid = 1'b0;

      for (int i = 0; i < 4; i++)
         if (touched[i])
            refill_line(i);
      $display("RESULT: PASS");
      $finish;
   end

endmodule

//--- rtl/cache_back_end.sv
`timescale 1ns/100ps
`include "cache_be_defs.svh"

module cache_back_end
   (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     write_valid,
    input  cache_be_pkg::fe_waddr_t  write_addr,
    input  cache_be_pkg::fe_word_t   write_wdata,
    input  cache_be_pkg::fe_strb_t   write_wstrb,
    output logic                     write_ready,
    input  logic                     replace_valid,
    input  cache_be_pkg::line_addr_t replace_addr,
    output logic                     replace_ready,
    output logic                     read_valid,
    output cache_be_pkg::beat_idx_t  read_addr,
    output cache_be_pkg::be_word_t   read_rdata,
    output logic                     mem_valid,
    output cache_be_pkg::be_addr_t   mem_addr,
    output cache_be_pkg::be_word_t   mem_wdata,
    output cache_be_pkg::be_strb_t   mem_wstrb,
    input  cache_be_pkg::be_word_t   mem_rdata,
    input  logic                     mem_ready
    );

   import cache_be_pkg::*;

   logic       wtb_valid;
   wtb_entry_t wtb_entry;
   logic       wtb_ready;
   logic       writes_drained;

   logic       write_mem_valid;
   be_addr_t   write_mem_addr;
   be_word_t   write_mem_wdata;
   be_strb_t   write_mem_wstrb;
   logic       write_mem_ready;

   logic       refill_mem_valid;
   be_addr_t   refill_mem_addr;
   logic       refill_mem_ready;

   write_through_buffer #(.DEPTH(`CACHE_WTB_DEPTH)) wtb0
     (.clk(clk), .reset(reset),
      .in_valid(write_valid), .in_ready(write_ready),
      .in_addr(write_addr), .in_wdata(write_wdata), .in_wstrb(write_wstrb),
      .out_valid(wtb_valid), .out_entry(wtb_entry), .out_ready(wtb_ready));

   write_through_ctrl wr_ctrl0
     (.clk(clk), .reset(reset),
      .wtb_valid(wtb_valid), .wtb_entry(wtb_entry), .wtb_ready(wtb_ready),
      .writes_drained(writes_drained),
      .write_mem_valid(write_mem_valid), .write_mem_addr(write_mem_addr),
      .write_mem_wdata(write_mem_wdata), .write_mem_wstrb(write_mem_wstrb),
      .write_mem_ready(write_mem_ready));

   line_refill_ctrl rf_ctrl0
     (.clk(clk), .reset(reset),
      .replace_valid(replace_valid), .replace_addr(replace_addr),
      .replace_ready(replace_ready), .writes_drained(writes_drained),
      .refill_mem_valid(refill_mem_valid), .refill_mem_addr(refill_mem_addr),
      .refill_mem_ready(refill_mem_ready), .mem_rdata(mem_rdata),
      .read_valid(read_valid), .read_addr(read_addr), .read_rdata(read_rdata));

   mem_port_arbiter arb0
     (.clk(clk), .reset(reset),
      .refill_mem_valid(refill_mem_valid), .refill_mem_addr(refill_mem_addr),
      .write_mem_valid(write_mem_valid), .write_mem_addr(write_mem_addr),
      .write_mem_wdata(write_mem_wdata), .write_mem_wstrb(write_mem_wstrb),
      .refill_mem_ready(refill_mem_ready), .write_mem_ready(write_mem_ready),
      .mem_valid(mem_valid), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
      .mem_wstrb(mem_wstrb), .mem_ready(mem_ready));

endmodule

//--- rtl/mem_port_arbiter.sv
`timescale 1ns/100ps

module mem_port_arbiter
   (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   refill_mem_valid,
    input  cache_be_pkg::be_addr_t refill_mem_addr,
    input  logic                   write_mem_valid,
    input  cache_be_pkg::be_addr_t write_mem_addr,
    input  cache_be_pkg::be_word_t write_mem_wdata,
    input  cache_be_pkg::be_strb_t write_mem_wstrb,
    output logic                   refill_mem_ready,
    output logic                   write_mem_ready,
    output logic                   mem_valid,
    output cache_be_pkg::be_addr_t mem_addr,
    output cache_be_pkg::be_word_t mem_wdata,
    output cache_be_pkg::be_strb_t mem_wstrb,
    input  logic                   mem_ready
    );

   import cache_be_pkg::*;

   typedef enum logic [1:0] {own_none, own_refill, own_write} owner_t;

   owner_t owner_q;
   owner_t prio;
   owner_t grant;

   // refill wins a fresh pick
   assign prio = refill_mem_valid ? own_refill :
                 write_mem_valid  ? own_write  : own_none;

   always_comb
   begin
      case (owner_q)
         own_write: grant = own_write;   // held until mem_ready
         default:   grant = prio;        // a running burst keeps winning by priority
      endcase
   end

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
         owner_q <= own_none;
      else if (grant == own_write && mem_ready)
         owner_q <= own_none;
      else
         owner_q <= grant;
   end

   assign mem_valid = ((grant == own_refill) && refill_mem_valid) ||
                      ((grant == own_write) && write_mem_valid);
   assign mem_addr  = (grant == own_write) ? write_mem_addr : refill_mem_addr;
   assign mem_wdata = (grant == own_write) ? write_mem_wdata : '0;
   assign mem_wstrb = (grant == own_write) ? write_mem_wstrb : '0;   // zero strobes mark a read

   assign refill_mem_ready = (grant == own_refill) && mem_ready;
   assign write_mem_ready  = (grant == own_write) && mem_ready;

endmodule

//--- rtl/line_refill_ctrl.sv
`timescale 1ns/100ps

module line_refill_ctrl
   (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     replace_valid,
    input  cache_be_pkg::line_addr_t replace_addr,
    output logic                     replace_ready,
    input  logic                     writes_drained,
    output logic                     refill_mem_valid,
    output cache_be_pkg::be_addr_t   refill_mem_addr,
    input  logic                     refill_mem_ready,
    input  cache_be_pkg::be_word_t   mem_rdata,
    output logic                     read_valid,
    output cache_be_pkg::beat_idx_t  read_addr,
    output cache_be_pkg::be_word_t   read_rdata
    );

   import cache_be_pkg::*;

   typedef enum logic [1:0]
   {
      rf_idle,
      rf_burst,
      rf_end
   } rf_state_t;

   rf_state_t  state_q;
   line_addr_t line_q;
   beat_idx_t  beat_q;

   // hold off until every earlier write is in memory
   assign replace_ready = (state_q == rf_idle) && writes_drained;

   assign refill_mem_valid = (state_q == rf_burst);
   assign refill_mem_addr  = {line_q, beat_q, 3'b000};

   // beats go straight to the line array
   assign read_valid = (state_q == rf_burst) && refill_mem_ready;
   assign read_addr  = beat_q;
   assign read_rdata = mem_rdata;

   always_ff @(posedge clk)
   begin
      if (replace_valid && replace_ready)
         line_q <= replace_addr;
   end

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         state_q <= rf_idle;
         beat_q  <= '0;
      end
      else
      begin
         case (state_q)
            rf_idle:
            begin
               if (replace_valid && replace_ready)
               begin
                  state_q <= rf_burst;
                  beat_q  <= '0;
               end
            end
            rf_burst:
            begin
               if (refill_mem_ready)
               begin
                  beat_q <= beat_q + 1'b1;   // wraps to 0 after the last beat
                  if (&beat_q)
                     state_q <= rf_end;
               end
            end
            rf_end:
            begin
               state_q <= rf_idle;   // last beat settles in the line array
            end
            default: state_q <= rf_idle;
         endcase
      end
   end

endmodule

//--- rtl/write_through_ctrl.sv
`timescale 1ns/100ps
`include "cache_be_defs.svh"

module write_through_ctrl
   (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     wtb_valid,
    input  cache_be_pkg::wtb_entry_t wtb_entry,
    output logic                     wtb_ready,
    output logic                     writes_drained,
    output logic                     write_mem_valid,
    output cache_be_pkg::be_addr_t   write_mem_addr,
    output cache_be_pkg::be_word_t   write_mem_wdata,
    output cache_be_pkg::be_strb_t   write_mem_wstrb,
    input  logic                     write_mem_ready
    );

   import cache_be_pkg::*;

   typedef enum logic {wr_idle, wr_busy} wr_state_t;

   wr_state_t  state_q;
   wtb_entry_t entry_q;
   logic       word_sel;

   assign wtb_ready       = (state_q == wr_idle);
   assign write_mem_valid = (state_q == wr_busy);
   assign writes_drained  = (state_q == wr_idle) && !wtb_valid;

   assign word_sel = entry_q.addr[0];   // byte address bit 2
   assign write_mem_addr = {entry_q.addr[$bits(fe_waddr_t)-1:1], 3'b000};

   // place the word in its half, other half unstrobed
   assign write_mem_wdata = word_sel ?
                            {entry_q.wdata, {`CACHE_FE_DATA_W{1'b0}}} :
                            {{`CACHE_FE_DATA_W{1'b0}}, entry_q.wdata};
   assign write_mem_wstrb = word_sel ?
                            {entry_q.wstrb, {$bits(fe_strb_t){1'b0}}} :
                            {{$bits(fe_strb_t){1'b0}}, entry_q.wstrb};

   always_ff @(posedge clk)
   begin
      if (wtb_valid && wtb_ready)
         entry_q <= wtb_entry;
   end

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
         state_q <= wr_idle;
      else
      begin
         case (state_q)
            wr_idle:
            begin
               if (wtb_valid)
                  state_q <= wr_busy;   // entry taken this edge
            end
            wr_busy:
            begin
               if (write_mem_ready)
                  state_q <= wr_idle;
            end
            default: state_q <= wr_idle;
         endcase
      end
   end

endmodule

//--- rtl/write_through_buffer.sv
`timescale 1ns/100ps
`include "cache_be_defs.svh"

module write_through_buffer
  #(
    parameter int DEPTH = `CACHE_WTB_DEPTH
    )
   (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    in_valid,
    output logic                    in_ready,
    input  cache_be_pkg::fe_waddr_t in_addr,
    input  cache_be_pkg::fe_word_t  in_wdata,
    input  cache_be_pkg::fe_strb_t  in_wstrb,
    output logic                    out_valid,
    output cache_be_pkg::wtb_entry_t out_entry,
    input  logic                    out_ready
    );

   import cache_be_pkg::*;

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   wtb_entry_t       mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             push;
   logic             pop;

   assign out_valid = (count != '0);
   assign in_ready  = (count != CNT_W'(DEPTH)) || out_ready;   // full but draining this cycle
   assign push      = in_valid && in_ready;
   assign pop       = out_valid && out_ready;
   assign out_entry = mem[rd_ptr];

   always_ff @(posedge clk)
   begin
      if (push)
      begin
         mem[wr_ptr] <= '{addr: in_addr, wdata: in_wdata, wstrb: in_wstrb};
      end
   end

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (push)
            wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;   // both or neither
         endcase
      end
   end

endmodule

//--- rtl/cache_be_pkg.sv
`include "cache_be_defs.svh"

package cache_be_pkg;

   // front-end side
   typedef logic [`CACHE_FE_DATA_W-1:0]   fe_word_t;
   typedef logic [`CACHE_FE_DATA_W/8-1:0] fe_strb_t;
   typedef logic [`CACHE_FE_ADDR_W-3:0]   fe_waddr_t;   // byte addr without 2 lsbs

   // memory side
   typedef logic [`CACHE_BE_DATA_W-1:0]   be_word_t;
   typedef logic [`CACHE_BE_DATA_W/8-1:0] be_strb_t;
   typedef logic [`CACHE_FE_ADDR_W-1:0]   be_addr_t;

   // line and beat
   typedef logic [`CACHE_FE_ADDR_W-3-`CACHE_WORD_OFF_W:0] line_addr_t;   // 27 bits
   typedef logic [`CACHE_LINE2MEM_W-1:0]                  beat_idx_t;

   // one pending write in the buffer
   typedef struct packed {
      fe_waddr_t addr;
      fe_word_t  wdata;
      fe_strb_t  wstrb;
   } wtb_entry_t;

endpackage

//--- rtl/cache_be_defs.svh
`ifndef CACHE_BE_DEFS_SVH
`define CACHE_BE_DEFS_SVH

// front-end byte address and word
`define CACHE_FE_ADDR_W 32
`define CACHE_FE_DATA_W 32

// memory word, two front-end words wide
`define CACHE_BE_DATA_W 64

// line geometry
`define CACHE_WORD_OFF_W 3   // 8 front-end words per line
`define CACHE_LINE2MEM_W 2   // 4 memory beats per line

// write-through buffer
`define CACHE_WTB_DEPTH 4

`endif
